// File: Bender.yml
package:
  name: l2_cache

sources:
  - l2_cache_pkg.sv
  - l2_directory.sv
  - l2_data_array.sv
  - l2_cache_control.sv
  - l2_cache.sv
  - target: simulation
    files:
      - l2_pmem_model.sv
      - l2_cache_tb.sv

// File: l2_cache.f
l2_cache_pkg.sv
l2_directory.sv
l2_data_array.sv
l2_cache_control.sv
l2_cache.sv
l2_pmem_model.sv
l2_cache_tb.sv

// File: l2_cache.sv
module l2_cache (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input l2_cache_pkg::addr_t mem_address,
	input l2_cache_pkg::line_t mem_wdata,
	input l2_cache_pkg::line_t pmem_rdata,
	input logic pmem_resp,
	output logic mem_resp,
	output l2_cache_pkg::line_t mem_rdata,
	output logic pmem_read,
	output logic pmem_write,
	output l2_cache_pkg::addr_t pmem_address,
	output l2_cache_pkg::line_t pmem_wdata
);
	import l2_cache_pkg::*;

	tag_t tag;
	index_t index;

	logic hit;
	way_t hit_way;
	way_t victim_way;
	logic victim_dirty;
	tag_t victim_tag;

	logic dir_fill;
	logic dir_mark_dirty;
	logic dir_clean;
	logic lru_touch;

	logic data_we;
	way_t data_way;
	logic data_fill;

	// the offset is dropped from the address split.
	assign tag = mem_address[ADDR_WIDTH-1 -: TAG_BITS];
	assign index = mem_address[OFFSET_BITS +: INDEX_BITS];

	l2_directory directory_i (
		.clk(clk),
		.rst_n(rst_n),
		.index(index),
		.tag(tag),
		.dir_fill(dir_fill),
		.dir_mark_dirty(dir_mark_dirty),
		.dir_clean(dir_clean),
		.lru_touch(lru_touch),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag)
	);

	l2_data_array data_array_i (
		.clk(clk),
		.index(index),
		.data_we(data_we),
		.data_way(data_way),
		.data_fill(data_fill),
		.mem_wdata(mem_wdata),
		.pmem_rdata(pmem_rdata),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.mem_rdata(mem_rdata),
		.pmem_wdata(pmem_wdata)
	);

	l2_cache_control control_i (
		.clk(clk),
		.rst_n(rst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.pmem_resp(pmem_resp),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.mem_resp(mem_resp),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.dir_fill(dir_fill),
		.dir_mark_dirty(dir_mark_dirty),
		.dir_clean(dir_clean),
		.lru_touch(lru_touch),
		.data_we(data_we),
		.data_way(data_way),
		.data_fill(data_fill)
	);

endmodule : l2_cache

// File: l2_cache_control.sv
module l2_cache_control (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input l2_cache_pkg::addr_t mem_address,
	input logic pmem_resp,
	input logic hit,
	input l2_cache_pkg::way_t hit_way,
	input l2_cache_pkg::way_t victim_way,
	input logic victim_dirty,
	input l2_cache_pkg::tag_t victim_tag,
	output logic mem_resp,
	output logic pmem_read,
	output logic pmem_write,
	output l2_cache_pkg::addr_t pmem_address,
	output logic dir_fill,
	output logic dir_mark_dirty,
	output logic dir_clean,
	output logic lru_touch,
	output logic data_we,
	output l2_cache_pkg::way_t data_way,
	output logic data_fill
);
	import l2_cache_pkg::*;

	typedef enum logic [2:0] {
		idle,
		lookup,
		write_back,
		fill,
		respond
	} state_t;

	state_t state;
	state_t next_state;

	logic request;
	index_t req_index;

	assign request = mem_read | mem_write;
	assign req_index = mem_address[OFFSET_BITS +: INDEX_BITS];

	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (request) begin
					next_state = lookup;
				end
			end
			lookup: begin
				if (hit) begin
					next_state = respond;
				end else if (victim_dirty) begin
					next_state = write_back;
				end else begin
					next_state = fill;
				end
			end
			write_back: begin
				if (pmem_resp) begin
					next_state = fill;
				end
			end
			// retry the lookup once the line is in.
			fill: begin
				if (pmem_resp) begin
					next_state = lookup;
				end
			end
			respond: begin
				next_state = idle;
			end
			default: begin
				next_state = idle;
			end
		endcase
	end

	always_comb begin
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		dir_fill = 1'b0;
		dir_mark_dirty = 1'b0;
		dir_clean = 1'b0;
		lru_touch = 1'b0;
		data_we = 1'b0;
		data_way = hit_way;
		data_fill = 1'b0;
		case (state)
			lookup: begin
				// write hit lands here.
				if (hit && mem_write) begin
					data_we = 1'b1;
					dir_mark_dirty = 1'b1;
				end
			end
			write_back: begin
				pmem_write = 1'b1;
				if (pmem_resp) begin
					dir_clean = 1'b1;
				end
			end
			fill: begin
				pmem_read = 1'b1;
				data_way = victim_way;
				data_fill = 1'b1;
				if (pmem_resp) begin
					data_we = 1'b1;
					dir_fill = 1'b1;
				end
			end
			respond: begin
				mem_resp = 1'b1;
				lru_touch = 1'b1;
			end
			default: ;
		endcase
	end

	// victim line during write-back, request line otherwise.
	always_comb begin
		if (state == write_back) begin
			pmem_address = {victim_tag, req_index, {OFFSET_BITS{1'b0}}};
		end else begin
			pmem_address = {mem_address[ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(pmem_read && pmem_write))
		else $error("pmem_read and pmem_write high together");

	// requester drops or changes the request after the response.
	assert property (@(posedge clk) disable iff (!rst_n) mem_resp |=> !mem_resp)
		else $error("mem_resp high for two cycles");

	assert property (@(posedge clk) disable iff (!rst_n) !(mem_read && mem_write))
		else $error("mem_read and mem_write high together");

endmodule : l2_cache_control

// File: l2_cache_pkg.sv
package l2_cache_pkg;

	// byte address and line geometry.
	localparam int ADDR_WIDTH = 16;
	localparam int LINE_WIDTH = 64;
	localparam int OFFSET_BITS = 3;

	// organization.
	localparam int NUM_WAYS = 4;
	localparam int INDEX_BITS = 3;
	localparam int NUM_SETS = 1 << INDEX_BITS;

	// whatever is left above index and offset.
	localparam int TAG_BITS = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

	// byte address as seen on both buses.
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// one whole line, the unit of every transfer.
	typedef logic [LINE_WIDTH-1:0] line_t;

	typedef logic [TAG_BITS-1:0] tag_t;

	typedef logic [INDEX_BITS-1:0] index_t;

	typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

	// bit 2 picks the half, bit 1 splits ways 0 and 1 and bit 0 ways 2 and 3.
	typedef logic [NUM_WAYS-2:0] plru_t;

endpackage : l2_cache_pkg

// File: l2_cache_tb.sv
module l2_cache_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import l2_cache_pkg::*;

	localparam int RESP_TIMEOUT = 200;
	localparam int RANDOM_OPS = 200;
	localparam int LINE_BITS = ADDR_WIDTH - OFFSET_BITS;
	localparam int NUM_LINES = 1 << LINE_BITS;

	logic clk;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	addr_t mem_address;
	line_t mem_wdata;
	logic mem_resp;
	line_t mem_rdata;
	logic pmem_read;
	logic pmem_write;
	addr_t pmem_address;
	line_t pmem_wdata;
	line_t pmem_rdata;
	logic pmem_resp;
	int read_count;
	int write_count;
	addr_t wb_address;
	line_t wb_data;
	int wb_reads;

	int errors;
	int predicted_wbs;
	logic [15:0] lfsr;

	// reference contents and a shadow of the directory.
	line_t ref_mem [NUM_LINES];
	tag_t model_tag [NUM_SETS][NUM_WAYS];
	logic model_valid [NUM_SETS][NUM_WAYS];
	logic model_dirty [NUM_SETS][NUM_WAYS];
	plru_t model_tree [NUM_SETS];

	l2_cache dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_wdata(mem_wdata),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp),
		.mem_resp(mem_resp),
		.mem_rdata(mem_rdata),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata)
	);

	l2_pmem_model pmem_i (
		.clk(clk),
		.rst_n(rst_n),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_rdata(pmem_rdata),
		.pmem_resp(pmem_resp),
		.read_count(read_count),
		.write_count(write_count),
		.wb_address(wb_address),
		.wb_data(wb_data),
		.wb_reads(wb_reads)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic line_t mem_pattern(logic [LINE_BITS-1:0] line_idx);
		return {4{line_idx, 3'b101}} ^ 64'h0123_4567_89ab_cdef;
	endfunction

	// galois lfsr stepped once per bit handed out.
	function automatic logic [63:0] lfsr_bits(int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic way_t tree_victim(plru_t tree);
		return tree[2] ? {1'b1, tree[0]} : {1'b0, tree[1]};
	endfunction

	function automatic plru_t tree_touch(plru_t tree, way_t way);
		plru_t t;
		t = tree;
		case (way)
			2'd0: t[2:1] = 2'b11;
			2'd1: t[2:1] = 2'b10;
			2'd2: t[2] = 1'b0;
			default: t[2] = 1'b0;
		endcase
		if (way[1]) begin
			t[0] = ~way[0];
		end
		return t;
	endfunction

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	endtask

	task automatic request(input logic is_write, input addr_t addr, input line_t wdata,
			output line_t rdata, output int cycles);
		int n;
		n = 0;
		@(posedge clk);
		#1;
		mem_read = !is_write;
		mem_write = is_write;
		mem_address = addr;
		mem_wdata = wdata;
		do begin
			@(negedge clk);
			n++;
		end while (!mem_resp && n < RESP_TIMEOUT);
		rdata = mem_rdata;
		cycles = n;
		if (!mem_resp) begin
			errors++;
			$display("no response within %0d cycles to the request at %h", RESP_TIMEOUT, addr);
			finish_run();
		end else begin
			@(posedge clk);
			#1;
			mem_read = 1'b0;
			mem_write = 1'b0;
		end
	endtask

	// predicts hit, victim and write-back, then runs and checks one request.
	task automatic access(input logic is_write, input addr_t addr, input line_t wdata,
			output int cycles);
		index_t idx;
		tag_t tag;
		way_t way;
		logic hit;
		logic wb;
		addr_t wb_addr;
		line_t wb_line;
		line_t rdata;
		int reads0;
		int writes0;
		idx = addr[OFFSET_BITS +: INDEX_BITS];
		tag = addr[ADDR_WIDTH-1 -: TAG_BITS];
		hit = 1'b0;
		way = '0;
		wb = 1'b0;
		wb_addr = '0;
		wb_line = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (model_valid[idx][w] && model_tag[idx][w] == tag) begin
				hit = 1'b1;
				way = way_t'(w);
			end
		end
		if (!hit) begin
			way = tree_victim(model_tree[idx]);
			if (model_valid[idx][way] && model_dirty[idx][way]) begin
				wb = 1'b1;
				wb_addr = {model_tag[idx][way], idx, 3'b000};
				wb_line = ref_mem[wb_addr[ADDR_WIDTH-1:OFFSET_BITS]];
				predicted_wbs++;
			end
			model_valid[idx][way] = 1'b1;
			model_tag[idx][way] = tag;
			model_dirty[idx][way] = 1'b0;
		end
		if (is_write) begin
			model_dirty[idx][way] = 1'b1;
		end
		model_tree[idx] = tree_touch(model_tree[idx], way);
		reads0 = read_count;
		writes0 = write_count;
		request(is_write, addr, wdata, rdata, cycles);
		if (is_write) begin
			ref_mem[addr[ADDR_WIDTH-1:OFFSET_BITS]] = wdata;
		end else begin
			check(rdata, ref_mem[addr[ADDR_WIDTH-1:OFFSET_BITS]], "read data");
		end
		check(read_count - reads0, hit ? 0 : 1, "physical reads");
		check(write_count - writes0, wb ? 1 : 0, "physical writes");
		if (wb) begin
			check(wb_address, wb_addr, "write-back address");
			check(wb_data, wb_line, "write-back data");
			check(wb_reads, reads0, "write-back ahead of the fill read");
		end
	endtask

	task automatic reset_test();
		repeat (8) begin
			@(negedge clk);
			check({mem_resp, pmem_read, pmem_write}, 3'b000, "outputs during reset");
		end
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check({mem_resp, pmem_read, pmem_write}, 3'b000, "outputs after reset");
	endtask

	task automatic hit_tests();
		int cycles;
		access(1'b0, 16'h0108, '0, cycles);
		access(1'b0, 16'h010c, '0, cycles);
		check(cycles, 3, "read hit latency");
		access(1'b1, 16'h0109, lfsr_bits(64), cycles);
		check(cycles, 3, "write hit latency");
		access(1'b0, 16'h010f, '0, cycles);
	endtask

	// set 5 starts cold and the fifth tag pushes out way 0.
	task automatic eviction_test();
		int cycles;
		int writes0;
		writes0 = write_count;
		for (int t = 0; t < 5; t++) begin
			access(1'b1, {tag_t'(10'h040 + t * 3), 3'd5, 3'b000}, lfsr_bits(64), cycles);
		end
		check(write_count - writes0, 1, "write-backs in the full set");
		check(wb_address, {tag_t'(10'h040), 3'd5, 3'b000}, "write-back of way 0");
	endtask

	task automatic random_test();
		int cycles;
		int wbs0;
		int writes0;
		logic [63:0] r;
		logic [63:0] hi;
		logic [63:0] off;
		index_t idx;
		wbs0 = predicted_wbs;
		writes0 = write_count;
		for (int i = 0; i < RANDOM_OPS; i++) begin
			r = lfsr_bits(2);
			idx = (r[1:0] == 2'd0) ? 3'd1 : ((r[1:0] == 2'd1) ? 3'd4 : 3'd6);
			hi = lfsr_bits(4);
			off = lfsr_bits(3);
			r = lfsr_bits(1);
			access(r[0], {hi[3:0], 6'h15, idx, off[2:0]}, lfsr_bits(64), cycles);
		end
		check(write_count - writes0, predicted_wbs - wbs0, "write-backs over the random run");
	endtask

	initial begin
		errors = 0;
		predicted_wbs = 0;
		lfsr = 16'd82;
		rst_n = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_address = '0;
		mem_wdata = '0;
		for (int i = 0; i < NUM_LINES; i++) begin
			ref_mem[i] = mem_pattern(LINE_BITS'(i));
		end
		for (int s = 0; s < NUM_SETS; s++) begin
			model_tree[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				model_valid[s][w] = 1'b0;
				model_dirty[s][w] = 1'b0;
				model_tag[s][w] = '0;
			end
		end
		reset_test();
		hit_tests();
		eviction_test();
		random_test();
		finish_run();
	end

endmodule : l2_cache_tb

// File: l2_data_array.sv
module l2_data_array (
	input logic clk,
	input l2_cache_pkg::index_t index,
	input logic data_we,
	input l2_cache_pkg::way_t data_way,
	input logic data_fill,
	input l2_cache_pkg::line_t mem_wdata,
	input l2_cache_pkg::line_t pmem_rdata,
	input l2_cache_pkg::way_t hit_way,
	input l2_cache_pkg::way_t victim_way,
	output l2_cache_pkg::line_t mem_rdata,
	output l2_cache_pkg::line_t pmem_wdata
);
	import l2_cache_pkg::*;

	line_t lines [NUM_SETS][NUM_WAYS];
	line_t write_line;

	// fill data from memory, else the upstream write.
	always_comb begin
		if (data_fill) begin
			write_line = pmem_rdata;
		end else begin
			write_line = mem_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (data_we) begin
			lines[index][data_way] <= write_line;
		end
	end

	// hit way goes upstream.
	assign mem_rdata = lines[index][hit_way];

	// victim way is the write-back source.
	assign pmem_wdata = lines[index][victim_way];

endmodule : l2_data_array

// File: l2_directory.sv
module l2_directory (
	input logic clk,
	input logic rst_n,
	input l2_cache_pkg::index_t index,
	input l2_cache_pkg::tag_t tag,
	input logic dir_fill,
	input logic dir_mark_dirty,
	input logic dir_clean,
	input logic lru_touch,
	output logic hit,
	output l2_cache_pkg::way_t hit_way,
	output l2_cache_pkg::way_t victim_way,
	output logic victim_dirty,
	output l2_cache_pkg::tag_t victim_tag
);
	import l2_cache_pkg::*;

	tag_t tags [NUM_SETS][NUM_WAYS];
	logic [NUM_WAYS-1:0] valid [NUM_SETS];
	logic [NUM_WAYS-1:0] dirty [NUM_SETS];
	plru_t plru [NUM_SETS];

	logic [NUM_WAYS-1:0] way_match;
	plru_t set_plru;

	// decode the tree into the way it points at.
	function automatic way_t plru_victim(plru_t tree);
		way_t way;
		if (!tree[2]) begin
			way = tree[1] ? way_t'(1) : way_t'(0);
		end else begin
			way = tree[0] ? way_t'(3) : way_t'(2);
		end
		return way;
	endfunction

	// point the tree away from the way just used.
	function automatic plru_t plru_update(plru_t tree, way_t way);
		plru_t upd;
		upd = tree;
		case (way)
			way_t'(0): begin
				upd[2] = 1'b1;
				upd[1] = 1'b1;
			end
			way_t'(1): begin
				upd[2] = 1'b1;
				upd[1] = 1'b0;
			end
			way_t'(2): begin
				upd[2] = 1'b0;
				upd[0] = 1'b1;
			end
			default: begin
				upd[2] = 1'b0;
				upd[0] = 1'b0;
			end
		endcase
		return upd;
	endfunction

	// tag compare over the indexed set.
	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_match[w] = valid[index][w] && (tags[index][w] == tag);
		end
	end

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (way_match[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	assign hit = |way_match;

	assign set_plru = plru[index];
	assign victim_way = plru_victim(set_plru);
	assign victim_dirty = dirty[index][victim_way];
	assign victim_tag = tags[index][victim_way];

	// control state of every set.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < NUM_SETS; s++) begin
				valid[s] <= '0;
				dirty[s] <= '0;
				plru[s] <= '0;
			end
		end else begin
			if (dir_fill) begin
				valid[index][victim_way] <= 1'b1;
				dirty[index][victim_way] <= 1'b0;
			end
			if (dir_mark_dirty) begin
				dirty[index][hit_way] <= 1'b1;
			end
			if (dir_clean) begin
				dirty[index][victim_way] <= 1'b0;
			end
			if (lru_touch) begin
				plru[index] <= plru_update(set_plru, hit_way);
			end
		end
	end

	// tag of the way being filled.
	always_ff @(posedge clk) begin
		if (dir_fill) begin
			tags[index][victim_way] <= tag;
		end
	end

	// a fill only ever brings in a tag that missed.
	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(way_match))
		else $error("more than one way matches the request tag");

endmodule : l2_directory

// File: l2_pmem_model.sv
module l2_pmem_model (
	input logic clk,
	input logic rst_n,
	input logic pmem_read,
	input logic pmem_write,
	input l2_cache_pkg::addr_t pmem_address,
	input l2_cache_pkg::line_t pmem_wdata,
	output l2_cache_pkg::line_t pmem_rdata,
	output logic pmem_resp,
	output int read_count,
	output int write_count,
	output l2_cache_pkg::addr_t wb_address,
	output l2_cache_pkg::line_t wb_data,
	output int wb_reads
);
	timeunit 1ns;
	timeprecision 1ps;
	import l2_cache_pkg::*;

	localparam int LATENCY = 4;
	localparam int LINE_BITS = ADDR_WIDTH - OFFSET_BITS;
	localparam int NUM_LINES = 1 << LINE_BITS;

	line_t mem [NUM_LINES];
	int wait_cnt;

	// every line is built from its full line address.
	function automatic line_t line_pattern(logic [LINE_BITS-1:0] line_idx);
		return {4{line_idx, 3'b101}} ^ 64'h0123_4567_89ab_cdef;
	endfunction

	initial begin
		for (int i = 0; i < NUM_LINES; i++) begin
			mem[i] = line_pattern(LINE_BITS'(i));
		end
	end

	assign pmem_rdata = mem[pmem_address[ADDR_WIDTH-1:OFFSET_BITS]];

	// one-cycle response after four request cycles.
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pmem_resp <= 1'b0;
			wait_cnt <= 0;
			read_count <= 0;
			write_count <= 0;
			wb_address <= '0;
			wb_data <= '0;
			wb_reads <= 0;
		end else begin
			pmem_resp <= 1'b0;
			if ((pmem_read || pmem_write) && !pmem_resp) begin
				if (wait_cnt == LATENCY - 1) begin
					wait_cnt <= 0;
					pmem_resp <= 1'b1;
					if (pmem_write) begin
						mem[pmem_address[ADDR_WIDTH-1:OFFSET_BITS]] <= pmem_wdata;
						write_count <= write_count + 1;
						wb_address <= pmem_address;
						wb_data <= pmem_wdata;
						// reads seen so far order the write-back against fills.
						wb_reads <= read_count;
					end else begin
						read_count <= read_count + 1;
					end
				end else begin
					wait_cnt <= wait_cnt + 1;
				end
			end
		end
	end

endmodule : l2_pmem_model
